// ==== sim/programStimulus.txt ====
// word count, program words from 0x40, store count, (address data) pairs, halt address
00000025
20000513 01900093 FF900113 002081B3
00352023 40208233 00452223 0020F2B3
00552423 0020E333 00652623 0020C3B3
00752823 00112433 00852A23 123454B7
00952C23 01852583 00B52E23 00108463
02152023 00109463 05500613 02C52023
00114463 02152223 0020C463 06600613
02C52223 00C006EF 02152423 02152423
02D52423 01468767 02152623 02E52623
0000006F
0000000C
00000200 00000012 00000204 00000020
00000208 00000019 0000020C FFFFFFF9
00000210 FFFFFFE0 00000214 00000001
00000218 12345000 0000021C 12345000
00000220 00000055 00000224 00000066
00000228 000000B8 0000022C 000000C8
000000D0

// ==== project.f ====
common/cpuPkg.sv
common/coreMemIf.sv
core/instrDecode.sv
core/aluUnit.sv
core/regFile.sv
core/cpuCore.sv
hdl/memRequest.sv
hdl/cpuTop.sv
sim/cpuTopTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f project.f --top-module cpuTopTb \
  -o simv > build.log 2>&1 &&
./obj_dir/simv > sim.log 2>&1 || { echo "build or run error"; cat build.log; exit 1; }
cat sim.log
! grep -q "Test FAILED" sim.log && grep -q "Test OK" sim.log || exit 1

// ==== sim/cpuTopTb.sv ====
// Processor top testbench

`timescale 1ns/1ns

module cpuTopTb;

  localparam logic [31:0] startVec = 32'h0000_0040;
  localparam int memWords = 256;

  logic        clk;
  logic        rstN;
  logic        enable;
  logic [31:0] startAddr;
  logic [31:0] ramLoad;
  logic        busy;
  logic [31:0] ramAddr;
  logic [31:0] ramStore;
  logic        ren;
  logic        wen;

  // stimulus image and RAM contents
  logic [31:0] stim [0:127];
  logic [31:0] mem [memWords];

  int progLen;
  int storeCount;
  logic [31:0] haltAddr;
  int limitCycles = 0;

  // scoreboard state
  int storeIdx = 0;
  int storeErrs = 0;
  int resetErrs = 0;
  int holdChecks = 0;
  int holdErrs = 0;
  int haltCount = 0;
  int errCount = 0;
  int checkCount = 0;
  int waitLeft = 0;
  bit heldPrev = 0;
  bit firstSeen = 0;
  bit halted = 0;
  bit ok;
  logic [31:0] prevAddr;
  logic [31:0] prevStore;

  cpuTop #(.regCount(32)) dut (
    .clk       (clk),
    .rstN      (rstN),
    .enable    (enable),
    .startAddr (startAddr),
    .ramLoad   (ramLoad),
    .busy      (busy),
    .ramAddr   (ramAddr),
    .ramStore  (ramStore),
    .ren       (ren),
    .wen       (wen)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic checkEq(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg, output bit good);
    checkCount++;
    good = (actual === expected);
    if (!good) begin
      errCount++;
      $display("Mismatch at %0t ns: %s got %h expected %h", $time, msg, actual, expected);
    end
  endtask

  // RAM model keeps busy high in the first cycle of a request
  always @(posedge clk) begin
    if (rstN && (ren || wen)) begin
      if (heldPrev) begin
        holdChecks++;
        checkEq(ramAddr, prevAddr, "ramAddr moved under busy", ok);
        if (!ok) holdErrs++;
        checkEq(ramStore, prevStore, "ramStore moved under busy", ok);
        if (!ok) holdErrs++;
      end
      if (!busy) begin
        // access completes at this edge
        if (!firstSeen) begin
          checkEq(ramAddr, startAddr, "first fetch address", ok);
          if (!ok) resetErrs++;
          firstSeen = 1'b1;
        end
        if (wen) begin
          if (storeIdx >= storeCount) begin
            $display("Error: extra store of %h to address %h at %0t ns",
                     ramStore, ramAddr, $time);
            errCount++;
            storeErrs++;
          end else begin
            checkEq(ramAddr, stim[progLen + 2 + 2 * storeIdx], "store address", ok);
            if (!ok) storeErrs++;
            checkEq(ramStore, stim[progLen + 3 + 2 * storeIdx], "store data", ok);
            if (!ok) storeErrs++;
            storeIdx++;
          end
          mem[ramAddr[9:2]] = ramStore;
        end
        haltCount = (ren && ramAddr == haltAddr) ? haltCount + 1 : 0;
        if (haltCount >= 2) halted = 1'b1;
        heldPrev = 1'b0;
        busy <= 1'b1;
        waitLeft = $urandom % 4;
      end else begin
        heldPrev = 1'b1;
        prevAddr = ramAddr;
        prevStore = ramStore;
        if (waitLeft == 0) begin
          busy <= 1'b0;
          ramLoad <= mem[ramAddr[9:2]];
        end else begin
          waitLeft--;
        end
      end
    end
  end

  // watchdog sized from the program length
  initial begin
    wait (limitCycles > 0);
    repeat (limitCycles) @(posedge clk);
    $display("Error: timeout, the program never reached its halt loop");
    $display("Test FAILED");
    $finish;
  end

  initial begin
    void'($urandom(32'h7dc42bbf));
    rstN = 1'b0;
    enable = 1'b0;
    startAddr = startVec;
    ramLoad = '0;
    busy = 1'b1;
    for (int i = 0; i < 128; i++) begin
      stim[i] = '0;
    end
    $readmemh("sim/programStimulus.txt", stim);
    progLen = stim[0];
    storeCount = stim[progLen + 1];
    haltAddr = stim[progLen + 2 + 2 * storeCount];
    // fill depends on the whole word address
    for (int i = 0; i < memWords; i++) begin
      mem[i] = 32'hC0DE_0000 ^ (i * 32'h0001_0001);
    end
    for (int i = 0; i < progLen; i++) begin
      mem[startVec[9:2] + i] = stim[1 + i];
    end
    limitCycles = 40 * progLen * 8;

    repeat (2) @(posedge clk);
    rstN <= 1'b1;
    // port stays quiet while enable is low
    repeat (4) begin
      @(negedge clk);
      checkEq({31'b0, ren}, 32'd0, "ren while disabled", ok);
      if (!ok) resetErrs++;
      checkEq({31'b0, wen}, 32'd0, "wen while disabled", ok);
      if (!ok) resetErrs++;
    end
    @(posedge clk);
    enable <= 1'b1;

    // first completed fetch closes the reset and enable test
    wait (firstSeen);
    $display("reset and enable: %s", (resetErrs == 0) ? "pass" : "fail");

    wait (halted);
    @(negedge clk);
    $display("store sequence: %0d of %0d stores seen, %0d bad",
             storeIdx, storeCount, storeErrs);
    $display("back-pressure: %0d held cycles, %0d unstable", holdChecks, holdErrs);
    if (storeIdx != storeCount) begin
      $display("Error: halt reached with %0d stores missing", storeCount - storeIdx);
      errCount++;
    end
    $display("halt: reached at %h", haltAddr);
    $display("tests 4, checks %0d, errors %0d", checkCount, errCount);
    if (errCount == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== hdl/cpuTop.sv ====
// Processor top level

`timescale 1ns/1ns

module cpuTop #(
  parameter int regCount = 32
) (
  input  logic        clk,
  input  logic        rstN,
  input  logic        enable,
  input  logic [31:0] startAddr,
  input  logic [31:0] ramLoad,
  input  logic        busy,
  output logic [31:0] ramAddr,
  output logic [31:0] ramStore,
  output logic        ren,
  output logic        wen
);

  // fetch and data requests between core and port sequencer
  coreMemIf memBus ();

  cpuCore #(.regCount(regCount)) core (
    .clk       (clk),
    .rstN      (rstN),
    .startAddr (startAddr),
    .mem       (memBus.core)
  );

  memRequest req (
    .clk      (clk),
    .rstN     (rstN),
    .enable   (enable),
    .busy     (busy),
    .ramLoad  (ramLoad),
    .ramAddr  (ramAddr),
    .ramStore (ramStore),
    .ren      (ren),
    .wen      (wen),
    .mem      (memBus.request)
  );

endmodule

// ==== hdl/memRequest.sv ====
// Shared RAM port sequencer

`timescale 1ns/1ns

module memRequest (
  input  logic                    clk,
  input  logic                    rstN,
  input  logic                    enable,
  input  logic                    busy,
  input  logic [cpuPkg::xLen-1:0] ramLoad,
  output logic [cpuPkg::xLen-1:0] ramAddr,
  output logic [cpuPkg::xLen-1:0] ramStore,
  output logic                    ren,
  output logic                    wen,
  coreMemIf.request               mem
);

  typedef enum logic [1:0] {
    stIdle,
    stFetch,
    stData,
    stDone
  } reqState;

  reqState                 state;
  logic [cpuPkg::xLen-1:0] instrReg;
  logic [cpuPkg::xLen-1:0] loadReg;
  logic                    fetchIsMem;

  // peek at the returning opcode so the data phase follows without a gap
  assign fetchIsMem = (ramLoad[6:0] == cpuPkg::opLoad) || (ramLoad[6:0] == cpuPkg::opStore);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= stIdle;
    end else begin
      case (state)
        stIdle:
          if (enable) state <= stFetch;
        stFetch:
          // held until busy drops
          if (!busy) state <= fetchIsMem ? stData : stDone;
        stData:
          // illegal load/store encodings skip the access
          if (!(mem.dRead || mem.dWrite) || !busy) state <= stDone;
        stDone:
          state <= enable ? stFetch : stIdle;
        default:
          state <= stIdle;
      endcase
    end
  end

  // instruction and load data latches
  always_ff @(posedge clk) begin
    if (state == stFetch && !busy) instrReg <= ramLoad;
    if (state == stData && mem.dRead && !busy) loadReg <= ramLoad;
  end

  assign ren      = (state == stFetch) || (state == stData && mem.dRead);
  assign wen      = (state == stData) && mem.dWrite;
  assign ramAddr  = (state == stFetch) ? mem.pc : mem.dAddr;
  assign ramStore = mem.dStore;

  assign mem.instr  = instrReg;
  assign mem.dLoad  = loadReg;
  assign mem.iReady = (state == stDone);

  // one access at a time on the port
  assert property (@(posedge clk) disable iff (!rstN) !(ren && wen));

  // held request keeps address and data steady under busy
  assert property (@(posedge clk) disable iff (!rstN)
    (ren || wen) && busy |=> $stable(ramAddr) && $stable(ramStore));

endmodule

// ==== core/cpuCore.sv ====
// Processor core datapath

`timescale 1ns/1ns

module cpuCore #(
  parameter int regCount = 32
) (
  input  logic                    clk,
  input  logic                    rstN,
  input  logic [cpuPkg::xLen-1:0] startAddr,
  coreMemIf.core                  mem
);

  logic [4:0]              rs1, rs2, rd;
  cpuPkg::instrClass       cls;
  cpuPkg::aluOp            op;
  cpuPkg::branchCond       cond;
  logic [cpuPkg::xLen-1:0] imm;
  logic                    regWrite;
  logic                    aluSrcImm;
  logic [cpuPkg::xLen-1:0] rData1, rData2;
  logic [cpuPkg::xLen-1:0] aluB, aluResult;
  logic                    aluZero;
  logic [cpuPkg::xLen-1:0] pc, pcPlus4, nextPc, wbData;
  logic                    branchTaken;

  instrDecode decode (
    .instr     (mem.instr),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd        (rd),
    .cls       (cls),
    .op        (op),
    .cond      (cond),
    .imm       (imm),
    .regWrite  (regWrite),
    .aluSrcImm (aluSrcImm)
  );

  // write only when the request unit commits the instruction
  regFile #(.regCount(regCount)) regs (
    .clk    (clk),
    .rstN   (rstN),
    .we     (mem.iReady && regWrite),
    .rs1    (rs1),
    .rs2    (rs2),
    .rd     (rd),
    .wData  (wbData),
    .rData1 (rData1),
    .rData2 (rData2)
  );

  assign aluB = aluSrcImm ? imm : rData2;

  aluUnit alu (
    .op       (op),
    .a        (rData1),
    .b        (aluB),
    .result   (aluResult),
    .zero     (aluZero),
    .negative ()
  );

  assign pcPlus4 = pc + 32'd4;

  // beq/bne use the sub result, blt the slt result
  always_comb begin
    case (cond)
      cpuPkg::brEq: branchTaken = aluZero;
      cpuPkg::brNe: branchTaken = !aluZero;
      cpuPkg::brLt: branchTaken = aluResult[0];
      default:      branchTaken = 1'b0;
    endcase
  end

  always_comb begin
    case (cls)
      cpuPkg::classBranch: nextPc = branchTaken ? pc + imm : pcPlus4;
      cpuPkg::classJal:    nextPc = pc + imm;
      // jalr clears bit 0 of rs1 + imm
      cpuPkg::classJalr:   nextPc = aluResult & ~32'd1;
      default:             nextPc = pcPlus4;
    endcase
  end

  // write-back source
  always_comb begin
    case (cls)
      cpuPkg::classLoad:   wbData = mem.dLoad;
      cpuPkg::classLui:    wbData = imm;
      cpuPkg::classJal,
      cpuPkg::classJalr:   wbData = pcPlus4;
      default:             wbData = aluResult;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc <= startAddr;
    end else if (mem.iReady) begin
      pc <= nextPc;
    end
  end

  // requests toward the request unit
  assign mem.pc     = pc;
  assign mem.dAddr  = aluResult;
  assign mem.dStore = rData2;
  assign mem.dRead  = (cls == cpuPkg::classLoad);
  assign mem.dWrite = (cls == cpuPkg::classStore);

  // every committed target lands on a word boundary
  assert property (@(posedge clk) disable iff (!rstN) mem.iReady |=> pc[1:0] == 2'b00);

endmodule

// ==== core/regFile.sv ====
// Integer register file

`timescale 1ns/1ns

module regFile #(
  parameter int regCount = 32
) (
  input  logic                    clk,
  input  logic                    rstN,
  input  logic                    we,
  input  logic [4:0]              rs1,
  input  logic [4:0]              rs2,
  input  logic [4:0]              rd,
  input  logic [cpuPkg::xLen-1:0] wData,
  output logic [cpuPkg::xLen-1:0] rData1,
  output logic [cpuPkg::xLen-1:0] rData2
);

  logic [cpuPkg::xLen-1:0] regs [regCount];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < regCount; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != 5'd0 && int'(rd) < regCount) begin
      // x0 never written
      regs[rd] <= wData;
    end
  end

  // async reads, x0 and unmapped registers read zero
  assign rData1 = (rs1 == 5'd0 || int'(rs1) >= regCount) ? '0 : regs[rs1];
  assign rData2 = (rs2 == 5'd0 || int'(rs2) >= regCount) ? '0 : regs[rs2];

  // decoder must never target a register beyond the file
  assert property (@(posedge clk) disable iff (!rstN) we |-> int'(rd) < regCount);

endmodule

// ==== core/aluUnit.sv ====
// Integer ALU

`timescale 1ns/1ns

module aluUnit (
  input  cpuPkg::aluOp            op,
  input  logic [cpuPkg::xLen-1:0] a,
  input  logic [cpuPkg::xLen-1:0] b,
  output logic [cpuPkg::xLen-1:0] result,
  output logic                    zero,
  output logic                    negative
);

  always_comb begin
    case (op)
      cpuPkg::aluAdd:   result = a + b;
      cpuPkg::aluSub:   result = a - b;
      cpuPkg::aluAnd:   result = a & b;
      cpuPkg::aluOr:    result = a | b;
      cpuPkg::aluXor:   result = a ^ b;
      // signed compare, 0 or 1
      cpuPkg::aluSlt:   result = {{(cpuPkg::xLen-1){1'b0}}, $signed(a) < $signed(b)};
      // lui path, b carries the upper immediate
      cpuPkg::aluPassB: result = b;
      default:          result = '0;
    endcase
  end

  // flags for branch resolution
  assign zero     = (result == '0);
  assign negative = result[cpuPkg::xLen-1];

endmodule

// ==== core/instrDecode.sv ====
// Instruction decoder

`timescale 1ns/1ns

module instrDecode (
  input  logic [cpuPkg::xLen-1:0] instr,
  output logic [4:0]              rs1,
  output logic [4:0]              rs2,
  output logic [4:0]              rd,
  output cpuPkg::instrClass       cls,
  output cpuPkg::aluOp            op,
  output cpuPkg::branchCond       cond,
  output logic [cpuPkg::xLen-1:0] imm,
  output logic                    regWrite,
  output logic                    aluSrcImm
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [cpuPkg::xLen-1:0] immI, immS, immB, immU, immJ;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // register fields sit at fixed positions
  assign rs1 = instr[19:15];
  assign rs2 = instr[24:20];
  assign rd  = instr[11:7];

  // immediate formats, all sign extended from bit 31
  assign immI = {{20{instr[31]}}, instr[31:20]};
  assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign immU = {instr[31:12], 12'b0};
  assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    // defaults describe a no-op
    cls       = cpuPkg::classIllegal;
    op        = cpuPkg::aluAdd;
    cond      = cpuPkg::brEq;
    imm       = immI;
    regWrite  = 1'b0;
    aluSrcImm = 1'b0;
    case (opcode)
      cpuPkg::opR: begin
        regWrite = 1'b1;
        cls      = cpuPkg::classR;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: op = cpuPkg::aluAdd;
          {7'b0100000, 3'b000}: op = cpuPkg::aluSub;
          {7'b0000000, 3'b111}: op = cpuPkg::aluAnd;
          {7'b0000000, 3'b110}: op = cpuPkg::aluOr;
          {7'b0000000, 3'b100}: op = cpuPkg::aluXor;
          {7'b0000000, 3'b010}: op = cpuPkg::aluSlt;
          default: begin
            cls      = cpuPkg::classIllegal;
            regWrite = 1'b0;
          end
        endcase
      end
      cpuPkg::opImm: begin
        // only addi
        if (funct3 == 3'b000) begin
          cls       = cpuPkg::classI;
          regWrite  = 1'b1;
          aluSrcImm = 1'b1;
        end
      end
      cpuPkg::opLui: begin
        cls       = cpuPkg::classLui;
        op        = cpuPkg::aluPassB;
        imm       = immU;
        regWrite  = 1'b1;
        aluSrcImm = 1'b1;
      end
      cpuPkg::opLoad: begin
        // word loads only
        if (funct3 == 3'b010) begin
          cls       = cpuPkg::classLoad;
          regWrite  = 1'b1;
          aluSrcImm = 1'b1;
        end
      end
      cpuPkg::opStore: begin
        imm = immS;
        if (funct3 == 3'b010) begin
          cls       = cpuPkg::classStore;
          aluSrcImm = 1'b1;
        end
      end
      cpuPkg::opBranch: begin
        imm = immB;
        cls = cpuPkg::classBranch;
        case (funct3)
          3'b000: begin
            cond = cpuPkg::brEq;
            op   = cpuPkg::aluSub;
          end
          3'b001: begin
            cond = cpuPkg::brNe;
            op   = cpuPkg::aluSub;
          end
          3'b100: begin
            cond = cpuPkg::brLt;
            op   = cpuPkg::aluSlt;
          end
          default: cls = cpuPkg::classIllegal;
        endcase
      end
      cpuPkg::opJal: begin
        cls      = cpuPkg::classJal;
        imm      = immJ;
        regWrite = 1'b1;
      end
      cpuPkg::opJalr: begin
        // target is rs1 + immI through the alu
        if (funct3 == 3'b000) begin
          cls       = cpuPkg::classJalr;
          regWrite  = 1'b1;
          aluSrcImm = 1'b1;
        end
      end
      default: ;
    endcase
  end

endmodule

// ==== common/coreMemIf.sv ====
// Core to request unit bus

`timescale 1ns/1ns

interface coreMemIf;

  // core side requests
  logic [cpuPkg::xLen-1:0] pc;
  logic [cpuPkg::xLen-1:0] dAddr;
  logic [cpuPkg::xLen-1:0] dStore;
  logic                    dRead;
  logic                    dWrite;

  // request unit returns
  logic [cpuPkg::xLen-1:0] instr;
  logic [cpuPkg::xLen-1:0] dLoad;
  // one cycle commit strobe
  logic                    iReady;

  modport core (output pc, dAddr, dStore, dRead, dWrite,
                input instr, dLoad, iReady);

  modport request (input pc, dAddr, dStore, dRead, dWrite,
                   output instr, dLoad, iReady);

endinterface

// ==== common/cpuPkg.sv ====
// RV32I subset core definitions

package cpuPkg;

  // datapath width
  localparam int xLen = 32;

  // major opcodes, instr[6:0]
  localparam logic [6:0] opR      = 7'b0110011;
  localparam logic [6:0] opImm    = 7'b0010011;
  localparam logic [6:0] opLui    = 7'b0110111;
  localparam logic [6:0] opLoad   = 7'b0000011;
  localparam logic [6:0] opStore  = 7'b0100011;
  localparam logic [6:0] opBranch = 7'b1100011;
  localparam logic [6:0] opJal    = 7'b1101111;
  localparam logic [6:0] opJalr   = 7'b1100111;

  // decoded instruction class
  typedef enum logic [3:0] {
    classR,
    classI,
    classLui,
    classLoad,
    classStore,
    classBranch,
    classJal,
    classJalr,
    classIllegal
  } instrClass;

  // alu function select
  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluXor,
    aluSlt,
    aluPassB
  } aluOp;

  // branch compare kind
  typedef enum logic [1:0] {
    brEq,
    brNe,
    brLt
  } branchCond;

endpackage
